// File: Makefile
TOP := tb_monitor_reporter

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module monitor_reporter -f build.f

sim:
	verilator --binary --timing --assert --top-module $(TOP) -f build.f -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
		echo "$$out"; \
		echo "$$out" | grep -qx "All checks passed"

clean:
	rm -rf obj_dir

// File: build.f
monitor_reporter_pkg.sv
event_scanner.sv
packet_fifo.sv
monbus_packer.sv
monitor_reporter.sv
tb_clock_gen.sv
tb_monitor_reporter.sv

// File: event_scanner.sv
// Event scanner: table register, event selection, reported flags, threshold and event count
`timescale 1ns/1ps

module event_scanner
        import monitor_reporter_pkg::*;
#(
        parameter int MAX_TRANS  = 16,
        parameter int ADDR_WIDTH = 32
) (
        input  logic                            aclk,
        input  logic                            arst_n,
        input  logic [MAX_TRANS-1:0]            trans_valid,
        input  logic [2*MAX_TRANS-1:0]          trans_state,
        input  logic [MAX_TRANS-1:0]            trans_timeout,
        input  logic [4*MAX_TRANS-1:0]          trans_code,
        input  logic [6*MAX_TRANS-1:0]          trans_channel,
        input  logic [ADDR_WIDTH*MAX_TRANS-1:0] trans_addr,
        input  logic                            cfg_error_enable,
        input  logic                            cfg_timeout_enable,
        input  logic                            cfg_compl_enable,
        input  logic                            cfg_threshold_enable,
        input  logic [15:0]                     active_threshold,
        input  logic                            wr_ready,
        output logic                            wr_valid,
        output queue_entry_t                    wr_data,
        output logic [15:0]                     event_count,
        output logic [MAX_TRANS-1:0]            event_reported
);

        localparam int IDX_W = (MAX_TRANS > 1) ? $clog2(MAX_TRANS) : 1;

        // Address is only zero-padded into the data field
        if (ADDR_WIDTH > DATA_W) begin : g_addr_check
                $error("ADDR_WIDTH wider than the packet data field");
        end

        // Registered copy of the table
        logic [MAX_TRANS-1:0]            r_valid;
        logic [2*MAX_TRANS-1:0]          r_state;
        logic [MAX_TRANS-1:0]            r_timeout;
        logic [4*MAX_TRANS-1:0]          r_code;
        logic [6*MAX_TRANS-1:0]          r_channel;
        logic [ADDR_WIDTH*MAX_TRANS-1:0] r_addr;

        logic [MAX_TRANS-1:0] r_reported;
        logic                 r_crossed;
        logic [15:0]          r_event_count;

        logic [MAX_TRANS-1:0] w_err_cand;
        logic [MAX_TRANS-1:0] w_tmo_cand;
        logic [MAX_TRANS-1:0] w_cpl_cand;
        logic [MAX_TRANS-1:0] w_pick;
        logic [IDX_W-1:0]     w_sel_idx;
        logic                 w_any_event;
        logic                 w_over;
        logic                 w_thresh_offer;
        logic                 w_wr_fire;
        logic [15:0]          w_active_count;

        assign event_count    = r_event_count;
        assign event_reported = r_reported;

        // Candidate slots per kind, plus the active count
        always_comb begin
                trans_state_e slot_state;
                w_err_cand     = '0;
                w_tmo_cand     = '0;
                w_cpl_cand     = '0;
                w_active_count = '0;
                for (int i = 0; i < MAX_TRANS; i++) begin
                        slot_state = trans_state_e'(r_state[2*i +: 2]);
                        if (r_valid[i] && !r_reported[i]) begin
                                w_err_cand[i] = cfg_error_enable &&
                                        ((slot_state == TRANS_ERROR && !r_timeout[i]) ||
                                         slot_state == TRANS_ORPHANED);
                                w_tmo_cand[i] = cfg_timeout_enable && r_timeout[i] &&
                                        slot_state == TRANS_ERROR;
                                w_cpl_cand[i] = cfg_compl_enable && slot_state == TRANS_COMPLETE;
                        end
                        if (r_valid[i] && slot_state != TRANS_COMPLETE &&
                            slot_state != TRANS_ERROR) begin
                                w_active_count = w_active_count + 16'd1;
                        end
                end
        end

        // Highest-priority kind first, then lowest slot index
        always_comb begin
                if (|w_err_cand) begin
                        w_pick = w_err_cand;
                end else if (|w_tmo_cand) begin
                        w_pick = w_tmo_cand;
                end else begin
                        w_pick = w_cpl_cand;
                end
                w_sel_idx = '0;
                for (int i = MAX_TRANS - 1; i >= 0; i--) begin
                        if (w_pick[i]) begin
                                w_sel_idx = IDX_W'(i);
                        end
                end
        end

        assign w_any_event    = |w_pick;
        assign w_over         = w_active_count > active_threshold;
        assign w_thresh_offer = !w_any_event && cfg_threshold_enable && w_over && !r_crossed;
        assign wr_valid       = w_any_event || w_thresh_offer;
        assign w_wr_fire      = wr_valid && wr_ready;

        // Queue entry for the selected event or the threshold report
        always_comb begin
                wr_data = '0;
                if (w_any_event) begin
                        if (|w_err_cand) begin
                                wr_data.pkt_type   = PKT_ERROR;
                                wr_data.event_code = r_code[4*w_sel_idx +: 4];
                        end else if (|w_tmo_cand) begin
                                wr_data.pkt_type   = PKT_TIMEOUT;
                                wr_data.event_code = r_code[4*w_sel_idx +: 4];
                        end else begin
                                wr_data.pkt_type   = PKT_COMPLETION;
                                wr_data.event_code = EVT_TRANS_COMPLETE;
                        end
                        wr_data.channel = r_channel[6*w_sel_idx +: 6];
                        wr_data.data    = DATA_W'(r_addr[ADDR_WIDTH*w_sel_idx +: ADDR_WIDTH]);
                end else if (w_thresh_offer) begin
                        wr_data.pkt_type   = PKT_THRESHOLD;
                        wr_data.event_code = EVT_THRESH_ACTIVE;
                        wr_data.data       = DATA_W'(w_active_count);
                end
        end

        // Table payload, qualified by r_valid
        always_ff @(posedge aclk) begin
                r_state   <= trans_state;
                r_timeout <= trans_timeout;
                r_code    <= trans_code;
                r_channel <= trans_channel;
                r_addr    <= trans_addr;
        end

        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        r_valid       <= '0;
                        r_reported    <= '0;
                        r_crossed     <= 1'b0;
                        r_event_count <= '0;
                end else begin
                        r_valid <= trans_valid;
                        for (int i = 0; i < MAX_TRANS; i++) begin
                                // Slot going invalid frees it for the next transaction
                                if (!r_valid[i]) begin
                                        r_reported[i] <= 1'b0;
                                end else if (w_wr_fire && w_any_event &&
                                             w_sel_idx == IDX_W'(i)) begin
                                        r_reported[i] <= 1'b1;
                                end
                        end
                        if (w_wr_fire && w_thresh_offer) begin
                                r_crossed <= 1'b1;
                        end else if (!w_over) begin
                                r_crossed <= 1'b0;
                        end
                        if (w_wr_fire) begin
                                r_event_count <= r_event_count + 16'd1;
                        end
                end
        end

        // Offered entry must hold until the FIFO takes it
        a_wr_hold: assert property (@(posedge aclk) disable iff (!arst_n)
                wr_valid && !wr_ready |=> wr_valid && $stable(wr_data));

endmodule : event_scanner

// File: monbus_packer.sv
// Monitor bus packer: output register and 64-bit packet formatting
`timescale 1ns/1ps

module monbus_packer
        import monitor_reporter_pkg::*;
#(
        parameter logic [3:0] UNIT_ID  = 4'd9,
        parameter logic [7:0] AGENT_ID = 8'd99
) (
        input  logic         aclk,
        input  logic         arst_n,
        input  logic         rd_valid,
        input  queue_entry_t rd_data,
        output logic         rd_ready,
        input  logic         monbus_ready,
        output logic         monbus_valid,
        output logic [63:0]  monbus_packet
);

        queue_entry_t r_entry;

        // Take a new entry when empty or when the held packet leaves
        assign rd_ready = !monbus_valid || monbus_ready;

        always_ff @(posedge aclk) begin
                if (rd_ready && rd_valid) begin
                        r_entry <= rd_data;
                end
        end

        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        monbus_valid <= 1'b0;
                end else if (rd_ready) begin
                        monbus_valid <= rd_valid;
                end
        end

        // type | protocol | event | channel | unit | agent | data
        assign monbus_packet = {
                r_entry.pkt_type,
                PROTOCOL_AXI,
                r_entry.event_code,
                r_entry.channel,
                UNIT_ID,
                AGENT_ID,
                r_entry.data
        };

        // Stalled packet is held unchanged
        a_pkt_hold: assert property (@(posedge aclk) disable iff (!arst_n)
                monbus_valid && !monbus_ready |=> monbus_valid && $stable(monbus_packet));

endmodule : monbus_packer

// File: monitor_reporter.sv
// Monitor reporter top: event scanner, packet FIFO and monitor bus packer
`timescale 1ns/1ps

module monitor_reporter
        import monitor_reporter_pkg::*;
#(
        parameter int         MAX_TRANS  = 16,
        parameter int         ADDR_WIDTH = 32,
        parameter int         FIFO_DEPTH = 8,
        parameter logic [3:0] UNIT_ID    = 4'd9,
        parameter logic [7:0] AGENT_ID   = 8'd99
) (
        input  logic                            aclk,
        input  logic                            arst_n,
        input  logic [MAX_TRANS-1:0]            trans_valid,
        input  logic [2*MAX_TRANS-1:0]          trans_state,
        input  logic [MAX_TRANS-1:0]            trans_timeout,
        input  logic [4*MAX_TRANS-1:0]          trans_code,
        input  logic [6*MAX_TRANS-1:0]          trans_channel,
        input  logic [ADDR_WIDTH*MAX_TRANS-1:0] trans_addr,
        input  logic                            cfg_error_enable,
        input  logic                            cfg_timeout_enable,
        input  logic                            cfg_compl_enable,
        input  logic                            cfg_threshold_enable,
        input  logic [15:0]                     active_threshold,
        input  logic                            monbus_ready,
        output logic                            monbus_valid,
        output logic [63:0]                     monbus_packet,
        output logic [15:0]                     event_count,
        output logic [MAX_TRANS-1:0]            event_reported
);

        // Scanner to FIFO
        logic         w_wr_valid;
        logic         w_wr_ready;
        queue_entry_t w_wr_data;

        // FIFO to packer
        logic         w_rd_valid;
        logic         w_rd_ready;
        queue_entry_t w_rd_data;

        event_scanner #(
                .MAX_TRANS  (MAX_TRANS),
                .ADDR_WIDTH (ADDR_WIDTH)
        ) i_scanner (
                .aclk                 (aclk),
                .arst_n               (arst_n),
                .trans_valid          (trans_valid),
                .trans_state          (trans_state),
                .trans_timeout        (trans_timeout),
                .trans_code           (trans_code),
                .trans_channel        (trans_channel),
                .trans_addr           (trans_addr),
                .cfg_error_enable     (cfg_error_enable),
                .cfg_timeout_enable   (cfg_timeout_enable),
                .cfg_compl_enable     (cfg_compl_enable),
                .cfg_threshold_enable (cfg_threshold_enable),
                .active_threshold     (active_threshold),
                .wr_ready             (w_wr_ready),
                .wr_valid             (w_wr_valid),
                .wr_data              (w_wr_data),
                .event_count          (event_count),
                .event_reported       (event_reported)
        );

        packet_fifo #(
                .FIFO_DEPTH (FIFO_DEPTH)
        ) i_fifo (
                .aclk     (aclk),
                .arst_n   (arst_n),
                .wr_valid (w_wr_valid),
                .wr_data  (w_wr_data),
                .wr_ready (w_wr_ready),
                .rd_ready (w_rd_ready),
                .rd_valid (w_rd_valid),
                .rd_data  (w_rd_data)
        );

        monbus_packer #(
                .UNIT_ID  (UNIT_ID),
                .AGENT_ID (AGENT_ID)
        ) i_packer (
                .aclk          (aclk),
                .arst_n        (arst_n),
                .rd_valid      (w_rd_valid),
                .rd_data       (w_rd_data),
                .rd_ready      (w_rd_ready),
                .monbus_ready  (monbus_ready),
                .monbus_valid  (monbus_valid),
                .monbus_packet (monbus_packet)
        );

endmodule : monitor_reporter

// File: monitor_reporter_pkg.sv
// Transaction state, packet type and event codes, protocol constant and report queue entry
package monitor_reporter_pkg;

        // State of one slot in the transaction table
        typedef enum logic [1:0] {
                TRANS_ACTIVE   = 2'd0,
                TRANS_COMPLETE = 2'd1,
                TRANS_ERROR    = 2'd2,
                TRANS_ORPHANED = 2'd3
        } trans_state_e;

        // Monitor bus packet types, upper nibble of the packet
        typedef enum logic [3:0] {
                PKT_ERROR      = 4'h0,
                PKT_COMPLETION = 4'h1,
                PKT_THRESHOLD  = 4'h2,
                PKT_TIMEOUT    = 4'h3
        } pkt_type_e;

        // Fixed event codes for packets that carry no slot code
        localparam logic [3:0] EVT_TRANS_COMPLETE = 4'h0;
        localparam logic [3:0] EVT_THRESH_ACTIVE  = 4'h1;

        // Protocol field, this monitor only ever reports AXI
        localparam logic [2:0] PROTOCOL_AXI = 3'b000;

        // Width of the packet data field
        localparam int DATA_W = 35;

        // One queued report, formatted into a bus packet by the packer
        // Data holds the padded address for events, the active count for thresholds
        typedef struct packed {
                pkt_type_e          pkt_type;
                logic [3:0]         event_code;
                logic [5:0]         channel;
                logic [DATA_W-1:0]  data;
        } queue_entry_t;

endpackage : monitor_reporter_pkg

// File: monitor_reporter_tests.txt
# test <name> <err_en> <tmo_en> <cpl_en> <thr_en> <threshold> <ready: 0 always, 1 random>
# slot <valid> <state 0 act 1 cpl 2 err 3 orph> <timeout> <code hex> <channel> <addr hex>
# pkt <type hex> <event hex> <channel> <data hex>, end <event_count step> <reported hex>
test priority 1 1 1 1 4 0
slot 1 1 0 7 5 00001000
slot 1 2 1 a 12 2000fff0
slot 1 2 0 3 33 80000004
slot 0 0 0 0 0 00000000
pkt 0 3 33 80000004
pkt 3 a 12 2000fff0
pkt 1 0 5 00001000
end 3 7
test index 1 1 1 0 0 0
slot 1 0 0 0 1 00000100
slot 1 1 0 4 17 0000a000
slot 0 1 0 0 0 00000000
slot 1 1 0 9 63 fffffffc
pkt 1 0 17 0000a000
pkt 1 0 63 fffffffc
end 2 a
test enables 1 0 1 0 15 0
slot 1 2 1 6 2 00000040
slot 1 3 0 5 8 00400000
slot 0 0 0 0 0 00000000
slot 1 1 0 2 40 12345678
pkt 0 5 8 00400000
pkt 1 0 40 12345678
end 2 a
test threshold 1 1 1 1 2 0
slot 1 0 0 0 1 00000010
slot 1 0 0 0 2 00000020
slot 1 0 0 0 3 00000030
slot 0 0 0 0 0 00000000
pkt 2 1 0 3
end 1 0
test backpressure 1 1 1 1 4 1
slot 1 1 0 7 5 00001000
slot 1 2 1 a 12 2000fff0
slot 1 2 0 3 33 80000004
slot 0 0 0 0 0 00000000
pkt 0 3 33 80000004
pkt 3 a 12 2000fff0
pkt 1 0 5 00001000
end 3 7

// File: packet_fifo.sv
// Packet FIFO: ring buffer of queue entries with a registered read stage
`timescale 1ns/1ps

module packet_fifo
        import monitor_reporter_pkg::*;
#(
        parameter int FIFO_DEPTH = 8
) (
        input  logic         aclk,
        input  logic         arst_n,
        input  logic         wr_valid,
        input  queue_entry_t wr_data,
        output logic         wr_ready,
        input  logic         rd_ready,
        output logic         rd_valid,
        output queue_entry_t rd_data
);

        localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

        queue_entry_t       r_mem [FIFO_DEPTH];
        logic [PTR_W-1:0]   r_wr_ptr;
        logic [PTR_W-1:0]   r_rd_ptr;
        logic [PTR_W:0]     r_count;
        logic               w_wr_fire;
        logic               w_load;

        assign wr_ready  = r_count != (PTR_W+1)'(FIFO_DEPTH);
        assign w_wr_fire = wr_valid && wr_ready;

        // Move the oldest entry into the output stage when it is free
        assign w_load = (r_count != '0) && (!rd_valid || rd_ready);

        always_ff @(posedge aclk) begin
                if (w_wr_fire) begin
                        r_mem[r_wr_ptr] <= wr_data;
                end
                if (w_load) begin
                        rd_data <= r_mem[r_rd_ptr];
                end
        end

        // Pointers wrap on their own since the depth is a power of two
        always_ff @(posedge aclk or negedge arst_n) begin
                if (!arst_n) begin
                        r_wr_ptr <= '0;
                        r_rd_ptr <= '0;
                        r_count  <= '0;
                        rd_valid <= 1'b0;
                end else begin
                        if (w_wr_fire) begin
                                r_wr_ptr <= r_wr_ptr + 1'b1;
                        end
                        if (w_load) begin
                                r_rd_ptr <= r_rd_ptr + 1'b1;
                                rd_valid <= 1'b1;
                        end else if (rd_ready) begin
                                rd_valid <= 1'b0;
                        end
                        r_count <= r_count + (PTR_W+1)'(w_wr_fire) - (PTR_W+1)'(w_load);
                end
        end

        // No write when full and no read when empty keep the occupancy in range
        a_no_write_full: assert property (@(posedge aclk) disable iff (!arst_n)
                (r_count <= (PTR_W+1)'(FIFO_DEPTH)));

        // Read pointer trails the write pointer by the occupancy
        a_no_read_empty: assert property (@(posedge aclk) disable iff (!arst_n)
                (r_rd_ptr + r_count[PTR_W-1:0]) == r_wr_ptr);

endmodule : packet_fifo

// File: tb_clock_gen.sv
// Testbench clock source with a configurable period
`timescale 1ns/1ps

module tb_clock_gen #(
        parameter int PERIOD_NS = 40
) (
        output logic clk
);

        initial begin
                clk = 1'b0;
        end

        // Free-running, half a period per phase
        always begin
                #(PERIOD_NS / 2);
                clk = ~clk;
        end

endmodule : tb_clock_gen

// File: tb_monitor_reporter.sv
// Testbench top: reads test blocks, drives the table on falling edges, checks bus packets
`timescale 1ns/1ps

module tb_monitor_reporter
        import monitor_reporter_pkg::*;
();

        localparam int         MAX_TRANS       = 4;
        localparam int         ADDR_WIDTH      = 32;
        localparam int         FIFO_DEPTH      = 4;
        localparam logic [3:0] UNIT_ID         = 4'd9;
        localparam logic [7:0] AGENT_ID        = 8'd99;
        localparam int         RESET_CYCLES    = 8;
        localparam int         CYCLES_PER_TEST = 200;
        localparam int         HOLD_CYCLES     = 12;

        logic                            aclk;
        logic                            arst_n;
        logic [MAX_TRANS-1:0]            trans_valid;
        logic [2*MAX_TRANS-1:0]          trans_state;
        logic [MAX_TRANS-1:0]            trans_timeout;
        logic [4*MAX_TRANS-1:0]          trans_code;
        logic [6*MAX_TRANS-1:0]          trans_channel;
        logic [ADDR_WIDTH*MAX_TRANS-1:0] trans_addr;
        logic                            cfg_error_enable;
        logic                            cfg_timeout_enable;
        logic                            cfg_compl_enable;
        logic                            cfg_threshold_enable;
        logic [15:0]                     active_threshold;
        logic                            monbus_ready;
        logic                            monbus_valid;
        logic [63:0]                     monbus_packet;
        logic [15:0]                     event_count;
        logic [MAX_TRANS-1:0]            event_reported;

        // Test being read from the data file
        string                           test_name;
        logic [MAX_TRANS-1:0]            nxt_valid;
        logic [2*MAX_TRANS-1:0]          nxt_state;
        logic [MAX_TRANS-1:0]            nxt_timeout;
        logic [4*MAX_TRANS-1:0]          nxt_code;
        logic [6*MAX_TRANS-1:0]          nxt_channel;
        logic [ADDR_WIDTH*MAX_TRANS-1:0] nxt_addr;
        logic [3:0]                      nxt_cfg;
        logic [15:0]                     nxt_threshold;
        logic                            nxt_random;
        logic [63:0]                     exp_q[$];
        logic [63:0]                     got_q[$];
        int                              exp_events;
        logic [MAX_TRANS-1:0]            exp_reported;

        logic   random_ready = 1'b0;
        integer seed         = 32'h95b4_931a;
        int     value_errors = 0;
        int     other_errors = 0;
        int     tests_read   = 0;
        int     cycle_count  = 0;
        int     cycle_limit  = RESET_CYCLES + 20;

        tb_clock_gen #(.PERIOD_NS(40)) i_clk (.clk(aclk));

        monitor_reporter #(
                .MAX_TRANS  (MAX_TRANS),
                .ADDR_WIDTH (ADDR_WIDTH),
                .FIFO_DEPTH (FIFO_DEPTH),
                .UNIT_ID    (UNIT_ID),
                .AGENT_ID   (AGENT_ID)
        ) i_dut (
                .aclk                 (aclk),
                .arst_n               (arst_n),
                .trans_valid          (trans_valid),
                .trans_state          (trans_state),
                .trans_timeout        (trans_timeout),
                .trans_code           (trans_code),
                .trans_channel        (trans_channel),
                .trans_addr           (trans_addr),
                .cfg_error_enable     (cfg_error_enable),
                .cfg_timeout_enable   (cfg_timeout_enable),
                .cfg_compl_enable     (cfg_compl_enable),
                .cfg_threshold_enable (cfg_threshold_enable),
                .active_threshold     (active_threshold),
                .monbus_ready         (monbus_ready),
                .monbus_valid         (monbus_valid),
                .monbus_packet        (monbus_packet),
                .event_count          (event_count),
                .event_reported       (event_reported)
        );

        // Bus packet layout, type in the top nibble and data in the low 35 bits
        function automatic logic [63:0] make_packet(input logic [3:0] pkt_type,
                                                    input logic [3:0] event_code,
                                                    input logic [5:0] channel,
                                                    input logic [34:0] data);
                return {pkt_type, PROTOCOL_AXI, event_code, channel, UNIT_ID, AGENT_ID, data};
        endfunction

        task automatic drive_ready();
                if (random_ready) begin
                        monbus_ready = 1'($random(seed));
                end else begin
                        monbus_ready = 1'b1;
                end
        endtask

        // Transfers are taken on the edge where valid and ready are both high
        always @(posedge aclk) begin
                if (arst_n && monbus_valid && monbus_ready) begin
                        got_q.push_back(monbus_packet);
                end
        end

        task automatic run_test();
                logic [15:0] base_count;
                @(negedge aclk);
                got_q.delete();
                base_count           = event_count;
                trans_valid          = nxt_valid;
                trans_state          = nxt_state;
                trans_timeout        = nxt_timeout;
                trans_code           = nxt_code;
                trans_channel        = nxt_channel;
                trans_addr           = nxt_addr;
                {cfg_error_enable, cfg_timeout_enable, cfg_compl_enable,
                 cfg_threshold_enable} = nxt_cfg;
                active_threshold     = nxt_threshold;
                random_ready         = nxt_random;
                drive_ready();
                while (got_q.size() < exp_q.size()) begin
                        @(negedge aclk);
                        drive_ready();
                end
                // Table held on so repeated reports would show up
                repeat (HOLD_CYCLES) begin
                        @(negedge aclk);
                        drive_ready();
                end
                assert (got_q.size() == exp_q.size()) else begin
                        value_errors++;
                        $display("[FAIL] %s packet count: expected %0d, actual %0d",
                                 test_name, exp_q.size(), got_q.size());
                end
                foreach (exp_q[i]) begin
                        assert (got_q[i] == exp_q[i]) else begin
                                value_errors++;
                                $display("[FAIL] %s packet %0d: expected %h, actual %h",
                                         test_name, i, exp_q[i], got_q[i]);
                        end
                end
                assert ((event_count - base_count) == 16'(exp_events)) else begin
                        value_errors++;
                        $display("[FAIL] %s event_count step: expected %0d, actual %0d",
                                 test_name, exp_events, event_count - base_count);
                end
                assert (event_reported == exp_reported) else begin
                        value_errors++;
                        $display("[FAIL] %s event_reported: expected %b, actual %b",
                                 test_name, exp_reported, event_reported);
                end
                // Invalid slots clear the reported flags before the next test
                trans_valid  = '0;
                random_ready = 1'b0;
                monbus_ready = 1'b1;
                repeat (2) @(negedge aclk);
        endtask

        initial begin : watchdog
                while (cycle_count <= cycle_limit) begin
                        @(posedge aclk);
                        cycle_count++;
                end
                other_errors++;
                $display("Run stopped after %0d cycles without finishing the tests", cycle_count);
                $display("Errors: %0d wrong values, %0d other failures",
                         value_errors, other_errors);
                $display("Checks failed");
                $finish;
        end

        initial begin : main
                logic [8*160-1:0] line;
                string            kw;
                int               fd;
                int               n;
                int               slot;
                int               f_err;
                int               f_tmo;
                int               f_cpl;
                int               f_thr;
                int               f_limit;
                int               f_mode;
                int               f_valid;
                int               f_state;
                int               f_chan;
                logic [3:0]       f_code;
                logic [31:0]      f_addr;
                logic [3:0]       p_type;
                logic [3:0]       p_event;
                logic [34:0]      p_data;
                arst_n               = 1'b0;
                trans_valid          = '0;
                trans_state          = '0;
                trans_timeout        = '0;
                trans_code           = '0;
                trans_channel        = '0;
                trans_addr           = '0;
                cfg_error_enable     = 1'b0;
                cfg_timeout_enable   = 1'b0;
                cfg_compl_enable     = 1'b0;
                cfg_threshold_enable = 1'b0;
                active_threshold     = '0;
                monbus_ready         = 1'b1;
                slot                 = 0;
                repeat (RESET_CYCLES) @(posedge aclk);
                @(negedge aclk);
                arst_n = 1'b1;
                fd = $fopen("monitor_reporter_tests.txt", "r");
                if (fd == 0) begin
                        other_errors++;
                        $display("Could not open the test data file");
                end else begin
                        while ($fgets(line, fd) != 0) begin
                                n = $sscanf(line, "%s", kw);
                                if (n < 1 || kw == "#") begin
                                        continue;
                                end
                                if (kw == "test") begin
                                        n = $sscanf(line, "%s %s %d %d %d %d %d %d", kw, test_name,
                                                    f_err, f_tmo, f_cpl, f_thr, f_limit, f_mode);
                                        nxt_cfg       = {1'(f_err), 1'(f_tmo), 1'(f_cpl), 1'(f_thr)};
                                        nxt_threshold = 16'(f_limit);
                                        nxt_random    = 1'(f_mode);
                                        nxt_valid     = '0;
                                        nxt_state     = '0;
                                        nxt_timeout   = '0;
                                        nxt_code      = '0;
                                        nxt_channel   = '0;
                                        nxt_addr      = '0;
                                        slot          = 0;
                                        exp_q.delete();
                                        tests_read++;
                                        cycle_limit = RESET_CYCLES + 20 + CYCLES_PER_TEST * tests_read;
                                end else if (kw == "slot" && slot < MAX_TRANS) begin
                                        n = $sscanf(line, "%s %d %d %d %h %d %h", kw, f_valid,
                                                    f_state, f_tmo, f_code, f_chan, f_addr);
                                        nxt_valid[slot]                          = 1'(f_valid);
                                        nxt_state[2*slot +: 2]                   = 2'(f_state);
                                        nxt_timeout[slot]                        = 1'(f_tmo);
                                        nxt_code[4*slot +: 4]                    = f_code;
                                        nxt_channel[6*slot +: 6]                 = 6'(f_chan);
                                        nxt_addr[ADDR_WIDTH*slot +: ADDR_WIDTH]  = f_addr;
                                        slot++;
                                end else if (kw == "pkt") begin
                                        n = $sscanf(line, "%s %h %h %d %h", kw, p_type, p_event,
                                                    f_chan, p_data);
                                        exp_q.push_back(make_packet(p_type, p_event, 6'(f_chan),
                                                                    p_data));
                                end else if (kw == "end") begin
                                        n = $sscanf(line, "%s %d %h", kw, exp_events, exp_reported);
                                        run_test();
                                end else begin
                                        other_errors++;
                                        $display("Unexpected line in the test data file: %s", kw);
                                end
                        end
                        $fclose(fd);
                end
                if (tests_read == 0) begin
                        other_errors++;
                        $display("No tests were found in the test data file");
                end
                $display("Errors: %0d wrong values, %0d other failures",
                         value_errors, other_errors);
                if (value_errors == 0 && other_errors == 0) begin
                        $display("All checks passed");
                end else begin
                        $display("Checks failed");
                end
                $finish;
        end

endmodule : tb_monitor_reporter
